/* verilog/rv32i_pkg.sv */
package rv32i_pkg;

    // datapath width
    localparam int xlen_bits = 32;
    // architectural register count
    localparam int reg_count = 32;
    // program order stamp width
    localparam int order_bits = 16;

    // major opcodes kept in this slice
    typedef enum logic [6:0] {
        op_b_lui = 7'b0110111,
        op_b_imm = 7'b0010011,
        op_b_reg = 7'b0110011
    } rv32i_opcode;

    // funct3 for integer arithmetic
    typedef enum logic [2:0] {
        arith_f3_add  = 3'b000,
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_funct3;

    // funct7 picks srl/sra and add/sub
    typedef enum logic [6:0] {
        base    = 7'b0000000,
        variant = 7'b0100000
    } funct7_kind;

    // low eight codes line up with funct3
    typedef enum logic [3:0] {
        alu_op_add  = 4'd0,
        alu_op_sll  = 4'd1,
        alu_op_slt  = 4'd2,
        alu_op_sltu = 4'd3,
        alu_op_xor  = 4'd4,
        alu_op_srl  = 4'd5,
        alu_op_or   = 4'd6,
        alu_op_and  = 4'd7,
        alu_op_sub  = 4'd8,
        alu_op_sra  = 4'd9,
        alu_op_none = 4'd10
    } alu_ops;

    // operand 1 source, no_out feeds zero
    typedef enum logic [1:0] {
        rs1_out = 2'b00,
        no_out  = 2'b01
    } alu_m1_sel_t;

    // operand 2 source
    typedef enum logic {
        rs2_out = 1'b0,
        imm_out = 1'b1
    } alu_m2_sel_t;

    // one instruction word, register view and immediate view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_t;

endpackage

/* verilog/if_id_if.sv */
`timescale 1ns/1ps

interface if_id_if;

    // buffered instruction, fetch buffer to decode
    logic                              valid;
    rv32i_pkg::instr_t                 inst;
    logic [rv32i_pkg::xlen_bits-1:0]   pc;
    logic [rv32i_pkg::order_bits-1:0]  order;

    // fetch buffer side
    modport src (output valid, output inst, output pc, output order);

    // decode side
    modport dst (input valid, input inst, input pc, input order);

endinterface

/* verilog/id_dis_if.sv */
`timescale 1ns/1ps

interface id_dis_if;

    logic                              valid;
    logic [rv32i_pkg::xlen_bits-1:0]   pc;
    logic [rv32i_pkg::order_bits-1:0]  order;
    // register addresses
    logic [4:0]                        rd_addr;
    logic [4:0]                        rs1_addr;
    logic [4:0]                        rs2_addr;
    // immediate already sign or shift extended
    logic [rv32i_pkg::xlen_bits-1:0]   imm;
    // control
    logic                              regf_we;
    rv32i_pkg::alu_m1_sel_t            alu_m1_sel;
    rv32i_pkg::alu_m2_sel_t            alu_m2_sel;
    rv32i_pkg::alu_ops                 aluop;

    // decode side
    modport src (
        output valid, output pc, output order,
        output rd_addr, output rs1_addr, output rs2_addr,
        output imm, output regf_we,
        output alu_m1_sel, output alu_m2_sel, output aluop
    );

    // execute side
    modport dst (
        input valid, input pc, input order,
        input rd_addr, input rs1_addr, input rs2_addr,
        input imm, input regf_we,
        input alu_m1_sel, input alu_m2_sel, input aluop
    );

endinterface

/* verilog/fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             stall,
    input  logic                             in_valid,
    input  logic [31:0]                      in_inst,
    input  logic [31:0]                      in_pc,
    if_id_if.src                             out
);

    logic                              buf_valid;
    logic [31:0]                       buf_inst;
    logic [31:0]                       buf_pc;
    logic [rv32i_pkg::order_bits-1:0]  buf_order;
    // next order number to hand out
    logic [rv32i_pkg::order_bits-1:0]  order_cnt;

    // control state, a bubble loads valid low
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
            order_cnt <= '0;
        end else if (!stall) begin
            buf_valid <= in_valid;
            // count only real instructions
            if (in_valid) begin
                order_cnt <= order_cnt + 1;
            end
        end
    end

    // payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            buf_inst  <= in_inst;
            buf_pc    <= in_pc;
            buf_order <= order_cnt;
        end
    end

    assign out.valid = buf_valid;
    assign out.inst  = buf_inst;
    assign out.pc    = buf_pc;
    assign out.order = buf_order;

endmodule

/* verilog/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic    stall,
    if_id_if.dst    in,
    id_dis_if.src   out
);

    logic [6:0]                       opcode;
    logic [2:0]                       funct3;
    logic [6:0]                       funct7;
    logic [4:0]                       rs1_addr;
    logic [4:0]                       rs2_addr;
    logic [4:0]                       rd_addr;
    logic [rv32i_pkg::xlen_bits-1:0]  i_imm;
    logic [rv32i_pkg::xlen_bits-1:0]  u_imm;

    // register and funct fields from the r view
    assign opcode   = in.inst.r.opcode;
    assign funct3   = in.inst.r.funct3;
    assign funct7   = in.inst.r.funct7;
    assign rs1_addr = in.inst.r.rs1;
    assign rs2_addr = in.inst.r.rs2;
    assign rd_addr  = in.inst.r.rd;

    // sign extended i-type immediate
    assign i_imm = {{20{in.inst.i.imm12[11]}}, in.inst.i.imm12};
    // upper 20 bits, low 12 cleared
    assign u_imm = {in.inst.i.imm12, in.inst.i.rs1, in.inst.i.funct3, 12'h000};

    always_comb begin
        // everything off by default
        out.valid      = 1'b0;
        out.pc         = '0;
        out.order      = '0;
        out.rd_addr    = '0;
        out.rs1_addr   = '0;
        out.rs2_addr   = '0;
        out.imm        = '0;
        out.regf_we    = 1'b0;
        out.alu_m1_sel = rv32i_pkg::rs1_out;
        out.alu_m2_sel = rv32i_pkg::rs2_out;
        // unknown opcodes compute zero
        out.aluop      = rv32i_pkg::alu_op_none;
        // stall drops valid, entry waits in the buffer
        if (!stall) begin
            out.valid    = in.valid;
            out.pc       = in.pc;
            out.order    = in.order;
            out.rd_addr  = rd_addr;
            out.rs1_addr = rs1_addr;
            out.rs2_addr = rs2_addr;
            unique case (opcode)
                rv32i_pkg::op_b_lui: begin
                    // rd = 0 + u_imm
                    out.imm        = u_imm;
                    out.regf_we    = 1'b1;
                    out.alu_m1_sel = rv32i_pkg::no_out;
                    out.alu_m2_sel = rv32i_pkg::imm_out;
                    out.aluop      = rv32i_pkg::alu_op_add;
                end
                rv32i_pkg::op_b_imm: begin
                    out.imm        = i_imm;
                    out.regf_we    = 1'b1;
                    out.alu_m1_sel = rv32i_pkg::rs1_out;
                    out.alu_m2_sel = rv32i_pkg::imm_out;
                    unique case (funct3)
                        rv32i_pkg::arith_f3_sr: begin
                            // imm[11:5] picks logical or arithmetic
                            unique case (funct7)
                                rv32i_pkg::base:    out.aluop = rv32i_pkg::alu_op_srl;
                                rv32i_pkg::variant: out.aluop = rv32i_pkg::alu_op_sra;
                                default:            out.aluop = rv32i_pkg::alu_op_srl;
                            endcase
                        end
                        // addi, slti, sltiu, xori, ori, andi, slli
                        default: out.aluop = rv32i_pkg::alu_ops'({1'b0, funct3});
                    endcase
                end
                rv32i_pkg::op_b_reg: begin
                    out.regf_we    = 1'b1;
                    out.alu_m1_sel = rv32i_pkg::rs1_out;
                    out.alu_m2_sel = rv32i_pkg::rs2_out;
                    unique case (funct3)
                        rv32i_pkg::arith_f3_sr: begin
                            unique case (funct7)
                                rv32i_pkg::base:    out.aluop = rv32i_pkg::alu_op_srl;
                                rv32i_pkg::variant: out.aluop = rv32i_pkg::alu_op_sra;
                                default:            out.aluop = rv32i_pkg::alu_op_none;
                            endcase
                        end
                        rv32i_pkg::arith_f3_add: begin
                            unique case (funct7)
                                rv32i_pkg::base:    out.aluop = rv32i_pkg::alu_op_add;
                                rv32i_pkg::variant: out.aluop = rv32i_pkg::alu_op_sub;
                                default:            out.aluop = rv32i_pkg::alu_op_none;
                            endcase
                        end
                        default: out.aluop = rv32i_pkg::alu_ops'({1'b0, funct3});
                    endcase
                end
                // anything else commits with no write
                default: ;
            endcase
        end
    end

endmodule

/* verilog/int_exec.sv */
`timescale 1ns/1ps

module int_exec (
    input  logic                                   clk,
    input  logic                                   rst,
    id_dis_if.dst                                  in,
    output logic                                   commit_valid,
    output logic [rv32i_pkg::order_bits-1:0]       commit_order,
    output logic [rv32i_pkg::xlen_bits-1:0]        commit_pc,
    output logic [4:0]                             commit_rd,
    output logic                                   commit_we,
    output logic [rv32i_pkg::xlen_bits-1:0]        commit_data
);

    logic [rv32i_pkg::xlen_bits-1:0]  regs [rv32i_pkg::reg_count];
    logic [rv32i_pkg::xlen_bits-1:0]  rs1_data;
    logic [rv32i_pkg::xlen_bits-1:0]  rs2_data;
    logic [rv32i_pkg::xlen_bits-1:0]  alu_a;
    logic [rv32i_pkg::xlen_bits-1:0]  alu_b;
    logic [rv32i_pkg::xlen_bits-1:0]  alu_result;
    logic                             wr_en;

    // x0 hardwired to zero on read
    assign rs1_data = (in.rs1_addr == 5'd0) ? '0 : regs[in.rs1_addr];
    assign rs2_data = (in.rs2_addr == 5'd0) ? '0 : regs[in.rs2_addr];

    // operand muxes
    always_comb begin
        unique case (in.alu_m1_sel)
            rv32i_pkg::rs1_out: alu_a = rs1_data;
            default:            alu_a = '0;
        endcase
        unique case (in.alu_m2_sel)
            rv32i_pkg::imm_out: alu_b = in.imm;
            default:            alu_b = rs2_data;
        endcase
    end

    // alu, shifts use the low five bits
    always_comb begin
        unique case (in.aluop)
            rv32i_pkg::alu_op_add:  alu_result = alu_a + alu_b;
            rv32i_pkg::alu_op_sub:  alu_result = alu_a - alu_b;
            rv32i_pkg::alu_op_sll:  alu_result = alu_a << alu_b[4:0];
            rv32i_pkg::alu_op_srl:  alu_result = alu_a >> alu_b[4:0];
            rv32i_pkg::alu_op_sra:  alu_result = $signed(alu_a) >>> alu_b[4:0];
            rv32i_pkg::alu_op_slt:
                alu_result = {{(rv32i_pkg::xlen_bits-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            rv32i_pkg::alu_op_sltu:
                alu_result = {{(rv32i_pkg::xlen_bits-1){1'b0}}, alu_a < alu_b};
            rv32i_pkg::alu_op_xor:  alu_result = alu_a ^ alu_b;
            rv32i_pkg::alu_op_or:   alu_result = alu_a | alu_b;
            rv32i_pkg::alu_op_and:  alu_result = alu_a & alu_b;
            // alu_op_none and unused codes
            default:                alu_result = '0;
        endcase
    end

    // write only real destinations
    assign wr_en = in.valid && in.regf_we && (in.rd_addr != 5'd0);

    // register file, same edge as the commit report
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv32i_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[in.rd_addr] <= alu_result;
        end
    end

    // commit control
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            commit_we    <= 1'b0;
        end else begin
            commit_valid <= in.valid;
            commit_we    <= wr_en;
        end
    end

    // commit payload, only loaded for real instructions
    always_ff @(posedge clk) begin
        if (in.valid) begin
            commit_order <= in.order;
            commit_pc    <= in.pc;
            commit_rd    <= in.rd_addr;
            commit_data  <= alu_result;
        end
    end

endmodule

/* verilog/decode_core.sv */
`timescale 1ns/1ps

module decode_core (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   in_valid,
    input  logic [31:0]                            in_inst,
    input  logic [31:0]                            in_pc,
    input  logic                                   stall,
    output logic                                   commit_valid,
    output logic [rv32i_pkg::order_bits-1:0]       commit_order,
    output logic [rv32i_pkg::xlen_bits-1:0]        commit_pc,
    output logic [4:0]                             commit_rd,
    output logic                                   commit_we,
    output logic [rv32i_pkg::xlen_bits-1:0]        commit_data
);

    // stage to stage links
    if_id_if  if_id ();
    id_dis_if id_dis ();

    // one cycle, holds under stall
    fetch_buffer u_fetch_buffer (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .in_pc    (in_pc),
        .out      (if_id.src)
    );

    // combinational
    decode u_decode (
        .stall (stall),
        .in    (if_id.dst),
        .out   (id_dis.src)
    );

    // regfile, alu and commit report
    int_exec u_int_exec (
        .clk          (clk),
        .rst          (rst),
        .in           (id_dis.dst),
        .commit_valid (commit_valid),
        .commit_order (commit_order),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_we    (commit_we),
        .commit_data  (commit_data)
    );

endmodule

/* verification/decode_core_sva.sv */
`timescale 1ns/1ps

module decode_core_sva (
    input logic       clk,
    input logic       rst,
    input logic       stall,
    input logic       in_valid,
    input logic       commit_valid,
    input logic       commit_we,
    input logic [4:0] commit_rd
);

    // sync reset clears the commit report
    a_idle_in_reset: assert property (@(posedge clk) rst |=> !commit_valid)
        else $error("commit_valid high after a reset cycle");

    // a write is always part of a commit
    a_we_needs_valid: assert property (@(posedge clk) disable iff (rst)
        commit_we |-> commit_valid)
        else $error("commit_we without commit_valid");

    // x0 never written
    a_we_not_x0: assert property (@(posedge clk) disable iff (rst)
        commit_we |-> (commit_rd != 5'd0))
        else $error("commit_we with rd zero");

    // stall kills decode valid, so nothing commits next edge
    a_stall_gap: assert property (@(posedge clk) disable iff (rst)
        stall |=> !commit_valid)
        else $error("commit after a stalled cycle");

    // a bubble reaches the commit ports two edges later
    a_bubble_gap: assert property (@(posedge clk) disable iff (rst)
        (!in_valid && !stall) |-> ##2 !commit_valid)
        else $error("commit from a bubble");

endmodule

bind decode_core decode_core_sva u_decode_core_sva (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .in_valid     (in_valid),
    .commit_valid (commit_valid),
    .commit_we    (commit_we),
    .commit_rd    (commit_rd)
);

/* verification/decode_core_tb.sv */
`timescale 1ns/1ps

module decode_core_tb;

    localparam int num_steps = 34;
    localparam int num_cols  = 7;
    localparam int num_groups = 5;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic        stall;
    logic        commit_valid;
    logic [15:0] commit_order;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic        commit_we;
    logic [31:0] commit_data;

    // one trace row per step holding stall, in_valid, inst, pc, rd, we and data
    logic [31:0] trace_mem [num_steps*num_cols];
    // expected commit as {pc, rd, we, data}
    logic [69:0] expected_q [$];

    int     errors;
    int     checks;
    int     group_errors;
    int     group_idx;
    int     commits_seen;
    int     group_end [num_groups] = '{10, 20, 22, 24, 26};
    string  group_name [num_groups] = '{"lui and op-imm", "op and dependency",
                                        "x0 writes", "unsupported opcode",
                                        "stall mid-stream"};

    decode_core u_decode_core (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_pc        (in_pc),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit_order (commit_order),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_we    (commit_we),
        .commit_data  (commit_data)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h expected %h", $time, what, got, exp);
            errors++;
            group_errors++;
        end
    endtask

    // sample on the falling edge where commit ports are settled
    always @(negedge clk) begin
        logic [69:0] rec;
        if (!rst && commit_valid) begin
            if (expected_q.size() == 0) begin
                $display("unexpected commit at %0t ns with nothing pending", $time);
                errors++;
            end else begin
                rec = expected_q.pop_front();
                check_value("commit_order", 32'(commit_order), 32'(commits_seen));
                check_value("commit_pc", commit_pc, rec[69:38]);
                check_value("commit_rd", 32'(commit_rd), 32'(rec[37:33]));
                check_value("commit_we", 32'(commit_we), 32'(rec[32]));
                check_value("commit_data", commit_data, rec[31:0]);
                commits_seen++;
                if (group_idx < num_groups && commits_seen == group_end[group_idx]) begin
                    $display("group %0d %s: %0d mismatches", group_idx + 1,
                             group_name[group_idx], group_errors);
                    group_errors = 0;
                    group_idx++;
                end
            end
        end
    end

    // watchdog scaled to the trace length
    initial begin
        #(num_steps * 20 + 400);
        $display("timeout: commits still pending after %0t ns", $time);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int idle_errors;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        stall = 1'b0;
        errors = 0;
        checks = 0;
        group_errors = 0;
        group_idx = 0;
        commits_seen = 0;
        $readmemh("verification/decode_trace.txt", trace_mem);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int s = 0; s < num_steps; s++) begin
            @(posedge clk);
            #1;
            stall    = trace_mem[s*num_cols][0];
            in_valid = trace_mem[s*num_cols+1][0];
            in_inst  = trace_mem[s*num_cols+2];
            in_pc    = trace_mem[s*num_cols+3];
            // accepted at the coming edge
            if (in_valid && !stall) begin
                expected_q.push_back({trace_mem[s*num_cols+3],
                                      trace_mem[s*num_cols+4][4:0],
                                      trace_mem[s*num_cols+5][0],
                                      trace_mem[s*num_cols+6]});
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        stall = 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        // trailing bubbles must stay quiet
        idle_errors = errors;
        repeat (4) @(posedge clk);
        $display("group 6 idle ports: %0d unexpected commits", errors - idle_errors);
        $display("checks %0d, commits %0d, errors %0d", checks, commits_seen, errors);
        if (errors == 0 && commits_seen == group_end[num_groups-1]) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verification/decode_trace.txt */
// stall in_valid inst pc expected_rd expected_we expected_data
// expected columns only matter on lines that are accepted
0 0 00000000 00000000 00 0 00000000
0 0 00000000 00000000 00 0 00000000
0 1 123450B7 00000100 01 1 12345000
0 1 FFB00113 00000104 02 1 FFFFFFFB
0 1 00112193 00000108 03 1 00000001
0 1 00113213 0000010C 04 1 00000000
0 1 0FF0C293 00000110 05 1 123450FF
0 1 00F0E313 00000114 06 1 1234500F
0 1 F000F393 00000118 07 1 12345000
0 1 00411413 0000011C 08 1 FFFFFFB0
0 1 00415493 00000120 09 1 0FFFFFFF
0 1 40415513 00000124 0A 1 FFFFFFFF
0 1 002085B3 00000128 0B 1 12344FFB
0 1 40158633 0000012C 0C 1 FFFFFFFB
0 1 008096B3 00000130 0D 1 50000000
0 1 00112733 00000134 0E 1 00000001
0 1 001137B3 00000138 0F 1 00000000
0 1 0020C833 0000013C 10 1 EDCBAFFB
0 1 009158B3 00000140 11 1 00000001
0 1 40915933 00000144 12 1 FFFFFFFF
0 1 0020E9B3 00000148 13 1 FFFFFFFB
0 1 0020FA33 0000014C 14 1 12345000
0 1 00008013 00000150 00 0 12345000
0 1 00000AB3 00000154 15 1 00000000
0 1 002082E3 00000158 05 0 00000000
0 1 00028B13 0000015C 16 1 123450FF
0 1 00700B93 00000160 17 1 00000007
1 1 001B8C13 00000164 18 1 00000008
1 1 001B8C13 00000164 18 1 00000008
0 1 001B8C13 00000164 18 1 00000008
0 0 00000000 00000000 00 0 00000000
0 0 00000000 00000000 00 0 00000000
0 0 00000000 00000000 00 0 00000000
0 0 00000000 00000000 00 0 00000000

/* all.f */
verilog/rv32i_pkg.sv
verilog/if_id_if.sv
verilog/id_dis_if.sv
verilog/fetch_buffer.sv
verilog/decode.sv
verilog/int_exec.sv
verilog/decode_core.sv
verification/decode_core_sva.sv
verification/decode_core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = decode_core_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
